//--- hw/proc_pkg.sv
package proc_pkg;

    localparam int WORD_W = 32;    // datapath width
    localparam int REG_W  = 5;     // register number width
    localparam int IMM_W  = 17;    // i-type immediate field
    localparam int EXC_W  = 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    // instruction opcodes, bits 31:27
    typedef enum logic [4:0] {
        OP_RTYPE = 5'd0,
        OP_ADDI  = 5'd5,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_e;

    // r-type function, bits 6:2
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    typedef enum logic [EXC_W-1:0] {
        EXC_NONE = 2'd0,
        EXC_ADD  = 2'd1,    // add overflow
        EXC_ADDI = 2'd2,    // addi overflow
        EXC_SUB  = 2'd3     // sub overflow
    } exc_code_e;

    localparam reg_idx_t EXC_REG = 5'd30;    // exception codes land here

    // decode -> execute
    typedef struct packed {
        logic     valid;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t shamt;
        alu_op_e  alu_op;
        word_t    imm;     // already sign extended
        word_t    a;       // rs value
        word_t    b;       // rt, or rd for sw
    } dx_t;

    // execute -> memory
    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_idx_t  rd;
        word_t     result;
        word_t     store_data;
        exc_code_e exc;
    } xm_t;

    // memory -> writeback
    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_idx_t  rd;
        word_t     result;
        word_t     load_data;
        exc_code_e exc;
    } mw_t;

endpackage

//--- hw/alu.sv
module alu import proc_pkg::*; (
    input  word_t    a,
    input  word_t    b,
    input  alu_op_e  op,
    input  reg_idx_t shamt,
    output word_t    result,
    output logic     overflow
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // same-sign operands, result sign flipped
    assign add_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
    // opposite signs, result takes b's sign
    assign sub_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

    always_comb begin
        result   = '0;    // unknown functions give zero
        overflow = 1'b0;
        case (op)
            ALU_ADD: begin
                result   = sum;
                overflow = add_ovf;
            end
            ALU_SUB: begin
                result   = diff;
                overflow = sub_ovf;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_SLL: begin
                result = a << shamt;    // shifts use a only
            end
            ALU_SRA: begin
                result = word_t'($signed(a) >>> shamt);
            end
            default: begin
                result   = '0;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/fetch_stage.sv
module fetch_stage import proc_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clock,
    input  logic  rst_n,
    input  word_t q_imem,      // instruction at pc, same cycle
    output word_t pc,
    output word_t fd_ir,
    output logic  fd_valid
);

    // program counter, no branches so it just counts
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc + word_t'(1);    // word addressed
        end
    end

    // fd pipeline register
    always_ff @(posedge clock) begin
        fd_ir <= q_imem;    // payload, no reset
    end

    // first real fetch happens the cycle after reset drops
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fd_valid <= 1'b0;
        end else begin
            fd_valid <= 1'b1;
        end
    end

endmodule

//--- hw/decode_stage.sv
module decode_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    fd_ir,
    input  logic     fd_valid,
    output reg_idx_t read_reg_a,
    output reg_idx_t read_reg_b,
    input  word_t    read_data_a,
    input  word_t    read_data_b,
    output dx_t      dx
);

    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t shamt;
    alu_op_e  alu_op;
    word_t    imm;
    dx_t      dx_next;

    // field split, r and i types share opcode/rd/rs
    assign opcode = opcode_e'(fd_ir[31:27]);
    assign rd     = fd_ir[26:22];
    assign rs     = fd_ir[21:17];
    assign rt     = fd_ir[16:12];
    assign shamt  = fd_ir[11:7];
    assign alu_op = alu_op_e'(fd_ir[6:2]);
    assign imm    = {{(WORD_W-IMM_W){fd_ir[IMM_W-1]}}, fd_ir[IMM_W-1:0]};    // sign extend

    // port a always rs
    assign read_reg_a = rs;
    // sw stores rd, so it goes out on port b
    assign read_reg_b = (opcode == OP_SW) ? rd : rt;

    always_comb begin
        dx_next.valid  = fd_valid;
        dx_next.opcode = opcode;
        dx_next.rd     = rd;
        dx_next.shamt  = shamt;
        dx_next.alu_op = alu_op;
        dx_next.imm    = imm;
        dx_next.a      = read_data_a;    // regfile answers same cycle
        dx_next.b      = read_data_b;
    end

    // dx register, only valid is cleared
    always_ff @(posedge clock) begin
        dx <= dx_next;
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end
    end

endmodule

//--- hw/execute_stage.sv
module execute_stage import proc_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    input  dx_t  dx,
    output xm_t  xm
);

    logic      use_imm;
    logic      is_rtype;
    word_t     alu_b;
    alu_op_e   alu_fn;
    word_t     alu_result;
    logic      alu_ovf;
    exc_code_e exc;
    xm_t       xm_next;

    assign is_rtype = (dx.opcode == OP_RTYPE);

    // addi and memory ops all add the immediate to rs
    assign use_imm = (dx.opcode == OP_ADDI) || (dx.opcode == OP_LW) || (dx.opcode == OP_SW);
    assign alu_b   = use_imm ? dx.imm : dx.b;
    assign alu_fn  = use_imm ? ALU_ADD : dx.alu_op;

    alu alu_i (
        .a        (dx.a),
        .b        (alu_b),
        .op       (alu_fn),
        .shamt    (dx.shamt),
        .result   (alu_result),
        .overflow (alu_ovf)
    );

    // overflow only counts for add, addi and sub
    always_comb begin
        exc = EXC_NONE;
        if (alu_ovf) begin
            if (is_rtype && dx.alu_op == ALU_ADD) begin
                exc = EXC_ADD;
            end else if (dx.opcode == OP_ADDI) begin
                exc = EXC_ADDI;
            end else if (is_rtype && dx.alu_op == ALU_SUB) begin
                exc = EXC_SUB;
            end
        end
    end

    always_comb begin
        xm_next.valid      = dx.valid;
        xm_next.opcode     = dx.opcode;
        xm_next.rd         = dx.rd;
        xm_next.result     = alu_result;    // also the dmem address
        xm_next.store_data = dx.b;          // rd value for sw
        xm_next.exc        = exc;
    end

    // xm register
    always_ff @(posedge clock) begin
        xm <= xm_next;
        if (!rst_n) begin
            xm.valid <= 1'b0;
        end
    end

endmodule

//--- hw/writeback_stage.sv
module writeback_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  xm_t      xm,
    input  word_t    q_dmem,         // load data, valid during memory cycle
    output logic     write_enable,
    output reg_idx_t write_reg,
    output word_t    write_data
);

    mw_t  mw;
    mw_t  mw_next;
    logic has_exc;
    logic writes_rd;

    always_comb begin
        mw_next.valid     = xm.valid;
        mw_next.opcode    = xm.opcode;
        mw_next.rd        = xm.rd;
        mw_next.result    = xm.result;
        mw_next.load_data = q_dmem;
        mw_next.exc       = xm.exc;
    end

    // mw register
    always_ff @(posedge clock) begin
        mw <= mw_next;
        if (!rst_n) begin
            mw.valid <= 1'b0;
        end
    end

    assign has_exc = (mw.exc != EXC_NONE);

    // sw writes nothing back
    assign writes_rd = (mw.opcode == OP_RTYPE) || (mw.opcode == OP_ADDI)
                    || (mw.opcode == OP_LW);

    assign write_enable = mw.valid && writes_rd;

    // exception redirects to r30 with the code as data
    assign write_reg = has_exc ? EXC_REG : mw.rd;

    always_comb begin
        if (has_exc) begin
            write_data = {{(WORD_W-EXC_W){1'b0}}, mw.exc};    // zero extend code
        end else if (mw.opcode == OP_LW) begin
            write_data = mw.load_data;
        end else begin
            write_data = mw.result;
        end
    end

endmodule

//--- hw/processor.sv
module processor import proc_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clock,
    input  logic     rst_n,
    // imem
    output word_t    address_imem,
    input  word_t    q_imem,
    // dmem
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    // regfile
    output logic     ctrl_write_enable,
    output reg_idx_t ctrl_write_reg,
    output reg_idx_t ctrl_read_reg_a,
    output reg_idx_t ctrl_read_reg_b,
    output word_t    data_write_reg,
    input  word_t    data_read_reg_a,
    input  word_t    data_read_reg_b
);

    word_t fd_ir;
    logic  fd_valid;
    dx_t   dx;
    xm_t   xm;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .q_imem   (q_imem),
        .pc       (address_imem),    // pc goes straight to imem
        .fd_ir    (fd_ir),
        .fd_valid (fd_valid)
    );

    decode_stage decode_stage_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .fd_ir       (fd_ir),
        .fd_valid    (fd_valid),
        .read_reg_a  (ctrl_read_reg_a),
        .read_reg_b  (ctrl_read_reg_b),
        .read_data_a (data_read_reg_a),
        .read_data_b (data_read_reg_b),
        .dx          (dx)
    );

    execute_stage execute_stage_i (
        .clock (clock),
        .rst_n (rst_n),
        .dx    (dx),
        .xm    (xm)
    );

    // memory stage is just the dmem ports
    assign address_dmem = xm.result;
    assign data         = xm.store_data;
    assign wren         = xm.valid && (xm.opcode == OP_SW);

    writeback_stage writeback_stage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .xm           (xm),
        .q_dmem       (q_dmem),
        .write_enable (ctrl_write_enable),
        .write_reg    (ctrl_write_reg),
        .write_data   (data_write_reg)
    );

endmodule

//--- sim/processor_assert.sv
module processor_assert import proc_pkg::*; (
    input logic  clock,
    input logic  rst_n,
    input word_t address_imem,
    input logic  wren,
    input logic  ctrl_write_enable
);

    timeunit 1ns;
    timeprecision 1ns;

    logic [2:0] fill_cnt;    // cycles since reset release, saturates at 7

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (fill_cnt != 3'd7) begin
            fill_cnt <= fill_cnt + 3'd1;
        end
    end

    // fetch restarts at address 0
    pc_after_reset: assert property (@(posedge clock) !rst_n |=> address_imem == '0)
        else $error("address_imem not at reset address after reset");

    // one word per cycle, never stalls
    pc_steps: assert property (@(posedge clock)
        rst_n |=> address_imem == $past(address_imem) + 32'd1)
        else $error("address_imem did not advance by one");

    // first sw can reach memory stage only after 3 cycles
    no_store_while_filling: assert property (@(posedge clock) disable iff (!rst_n)
        fill_cnt < 3'd3 |-> !wren)
        else $error("wren high while pipeline fills");

    // writeback needs one more
    no_write_while_filling: assert property (@(posedge clock) disable iff (!rst_n)
        fill_cnt < 3'd4 |-> !ctrl_write_enable)
        else $error("ctrl_write_enable high while pipeline fills");

endmodule

bind processor processor_assert processor_assert_i (
    .clock             (clock),
    .rst_n             (rst_n),
    .address_imem      (address_imem),
    .wren              (wren),
    .ctrl_write_enable (ctrl_write_enable)
);

//--- sim/tb_processor.sv
module tb_processor
    import proc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int N_INSTR      = 40;
    localparam int SLOTS        = 4;                            // instruction plus three nops
    localparam int RESET_CYCLES = 3;
    localparam int RUN_CYCLES   = N_INSTR * SLOTS + 10;         // program plus pipeline drain
    localparam int MAX_CYCLES   = RESET_CYCLES + RUN_CYCLES + 47;    // 220

    typedef struct packed {
        reg_idx_t idx;
        word_t    value;
    } reg_write_t;

    typedef struct packed {
        word_t addr;
        word_t value;
    } mem_write_t;

    logic     clock, rst_n, wren, ctrl_write_enable;
    word_t    address_imem, q_imem, address_dmem, data, q_dmem;
    word_t    data_write_reg, data_read_reg_a, data_read_reg_b;
    reg_idx_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;

    word_t imem [256];
    word_t dmem [64];
    word_t regs [32];
    word_t model_mem [64];
    word_t model_regs [32];
    word_t rng_state;
    reg_write_t reg_q [$];    // expected regfile writes in order
    mem_write_t mem_q [$];
    reg_write_t pend_reg;     // seen at negedge, committed at posedge
    mem_write_t pend_mem;
    logic pend_reg_we = 1'b0;
    logic pend_mem_we = 1'b0;
    int   cycle_count = 0;

    processor #(.RESET_PC(32'd0)) processor_i (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic word_t next_rand();    // lcg step
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic int unsigned pick(int unsigned n);
        return (next_rand() >> 16) % n;    // upper bits are the better ones
    endfunction

    function automatic word_t reg_init(int i);
        word_t v;
        v = (word_t'(i) * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
        if (i == 0) v = '0;
        if (i == 28) v = 32'h8000_0000;    // most negative, sub from it overflows
        if (i == 29) v = 32'h7FFF_FFFF;    // most positive, add and addi overflow
        return v;
    endfunction

    function automatic word_t mem_init(int a);
        return (word_t'(a) * 32'h0001_0003) ^ 32'hA5C3_0000 ^ word_t'(a);
    endfunction

    // true when a 64-bit result does not fit a signed word
    function automatic logic overflows(longint v);
        return v != longint'($signed(v[31:0]));
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(string what, word_t got, word_t expected);
        if (got !== expected) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic build_program();
        word_t       r;
        int unsigned kind;
        int          slot;
        reg_idx_t    rd, rs, rt, shamt;
        for (int i = 0; i < N_INSTR; i++) begin
            rd    = reg_idx_t'(1 + pick(29));    // r1..r29
            rs    = reg_idx_t'(1 + pick(29));
            rt    = reg_idx_t'(1 + pick(29));
            shamt = reg_idx_t'(pick(32));
            kind  = pick(10);
            r     = next_rand();
            slot  = i * SLOTS;
            // first three are add, addi and sub that overflow
            if (i < 3) begin
                rs    = (i == 2) ? 5'd28 : 5'd29;
                rt    = 5'd29;
                kind  = (i == 0) ? 0 : (i == 1) ? 6 : 1;
                r[31] = 1'b0;    // positive immediate
                r[15] = 1'b1;    // never zero
            end
            if (kind < 6) begin
                imem[slot[7:0]] = {OP_RTYPE, rd, rs, rt, shamt, 5'(kind), 2'b00};
            end else if (kind < 8) begin
                imem[slot[7:0]] = {OP_ADDI, rd, rs, r[31:15]};    // any sign
            end else if (kind == 8) begin
                imem[slot[7:0]] = {OP_SW, rd, 5'd0, 17'(pick(64))};
            end else begin
                imem[slot[7:0]] = {OP_LW, rd, 5'd0, 17'(pick(64))};
            end
        end
    endtask

    task automatic record_write(reg_idx_t idx, word_t value);
        reg_write_t w;
        w.idx   = idx;
        w.value = value;
        model_regs[idx] = value;
        if (idx != 0) reg_q.push_back(w);
    endtask

    // in-order execution, one instruction at a time
    task automatic run_model();
        word_t      ir, a, b, imm, res;
        opcode_e    op;
        alu_op_e    fn;
        exc_code_e  code;
        mem_write_t m;
        int         slot;
        for (int i = 0; i < N_INSTR; i++) begin
            slot = i * SLOTS;
            ir   = imem[slot[7:0]];
            op   = opcode_e'(ir[31:27]);
            fn   = alu_op_e'(ir[6:2]);
            a    = model_regs[ir[21:17]];
            b    = model_regs[ir[16:12]];
            imm  = {{15{ir[16]}}, ir[16:0]};
            res  = '0;
            code = EXC_NONE;
            case (op)
                OP_RTYPE: begin
                    case (fn)
                        ALU_ADD: begin
                            res = a + b;
                            if (overflows(longint'($signed(a)) + longint'($signed(b)))) begin
                                code = EXC_ADD;
                            end
                        end
                        ALU_SUB: begin
                            res = a - b;
                            if (overflows(longint'($signed(a)) - longint'($signed(b)))) begin
                                code = EXC_SUB;
                            end
                        end
                        ALU_AND: res = a & b;
                        ALU_OR:  res = a | b;
                        ALU_SLL: res = a << ir[11:7];
                        ALU_SRA: res = word_t'($signed(a) >>> ir[11:7]);
                        default: res = '0;
                    endcase
                end
                OP_ADDI: begin
                    res = a + imm;
                    if (overflows(longint'($signed(a)) + longint'($signed(imm)))) begin
                        code = EXC_ADDI;
                    end
                end
                OP_SW: begin
                    m.addr  = a + imm;    // base is r0
                    m.value = model_regs[ir[26:22]];
                    model_mem[m.addr[5:0]] = m.value;
                    mem_q.push_back(m);
                end
                OP_LW: begin
                    res = a + imm;
                    record_write(ir[26:22], model_mem[res[5:0]]);
                end
                default: res = '0;
            endcase
            if (op == OP_RTYPE || op == OP_ADDI) begin
                if (code != EXC_NONE) record_write(EXC_REG, {30'd0, code});    // rd untouched
                else record_write(ir[26:22], res);
            end
        end
    endtask

    // memories and regfile answer here, outputs are stable at this edge
    always @(negedge clock) begin
        reg_write_t exp_reg;
        mem_write_t exp_mem;
        q_imem          = imem[address_imem[7:0]];
        q_dmem          = dmem[address_dmem[5:0]];
        data_read_reg_a = (ctrl_read_reg_a == 0) ? '0 : regs[ctrl_read_reg_a];
        data_read_reg_b = (ctrl_read_reg_b == 0) ? '0 : regs[ctrl_read_reg_b];
        if (rst_n && ctrl_write_enable && ctrl_write_reg != 0) begin    // r0 writes are nops
            if (reg_q.size() == 0) begin
                $display("unexpected write to register %0d at %0t ns", ctrl_write_reg, $time);
                abort_run();
            end else begin
                exp_reg = reg_q.pop_front();
                check_equal("write register", {27'd0, ctrl_write_reg}, {27'd0, exp_reg.idx});
                check_equal("write data", data_write_reg, exp_reg.value);
            end
        end
        if (rst_n && wren) begin
            if (mem_q.size() == 0) begin
                $display("unexpected store to address %h at %0t ns", address_dmem, $time);
                abort_run();
            end else begin
                exp_mem = mem_q.pop_front();
                check_equal("store address", address_dmem, exp_mem.addr);
                check_equal("store data", data, exp_mem.value);
            end
        end
        pend_reg_we = rst_n && ctrl_write_enable;
        pend_reg    = {ctrl_write_reg, data_write_reg};
        pend_mem_we = rst_n && wren;
        pend_mem    = {address_dmem, data};
    end

    always @(posedge clock) begin
        if (pend_mem_we) dmem[pend_mem.addr[5:0]] = pend_mem.value;
        if (pend_reg_we && pend_reg.idx != 0) regs[pend_reg.idx] = pend_reg.value;
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, run did not finish", cycle_count);
            abort_run();
        end
    end

    initial begin
        rst_n           = 1'b0;
        q_imem          = '0;
        q_dmem          = '0;
        data_read_reg_a = '0;
        data_read_reg_b = '0;
        rng_state       = 32'd46574;
        imem            = '{default: '0};    // gaps are add r0, r0, r0
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]]       = reg_init(i);
            model_regs[i[4:0]] = reg_init(i);
        end
        for (int a = 0; a < 64; a++) begin
            dmem[a[5:0]]      = mem_init(a);
            model_mem[a[5:0]] = mem_init(a);
        end
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        repeat (RUN_CYCLES) @(posedge clock);
        if (reg_q.size() != 0 || mem_q.size() != 0) begin
            $display("%0d register writes and %0d stores never appeared", reg_q.size(),
                     mem_q.size());
            abort_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- filelist.f
hw/proc_pkg.sv
hw/alu.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/processor.sv
sim/processor_assert.sv
sim/tb_processor.sv

//--- run.sh
#!/usr/bin/env bash
# build the processor testbench with verilator and run it
# exit status is nonzero when the build or the simulation fails
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_processor \
    -f filelist.f \
    -o tb_processor_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/tb_processor_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit "$sim_status"
fi

exit 0
